//--- verilog/tcdm_probe_pkg.sv
/* widths, register indexes, burst length and FSM state shared by the TCDM probe RTL
   modules import what they need with a wildcard import in their body */
`default_nettype none

package tcdm_probe_pkg;

  // bus widths
  localparam int unsigned ADDR_W  = 20;  // tcdm byte address
  localparam int unsigned DATA_W  = 32;  // tcdm and apb data
  localparam int unsigned PADDR_W = 7;   // apb word index

  // burst geometry
  localparam int unsigned BURST_LEN = 64;                    // beats per burst
  localparam int unsigned CNT_W     = $clog2(BURST_LEN) + 1;  // msb flags the last beat

  // event lines
  localparam int unsigned SW_EVT_W = 14;            // software events, bits 15:2
  localparam int unsigned EVT_W    = SW_EVT_W + 2;  // plus fill and sum completion

  // register map, word indexes
  localparam logic [PADDR_W-1:0] REG_START_FILL = 7'h0;  // wr: fill base + start
  localparam logic [PADDR_W-1:0] REG_START_SUM  = 7'h1;  // wr: sum base + start
  localparam logic [PADDR_W-1:0] REG_DONE_FILL  = 7'h4;  // rd: fill done flag
  localparam logic [PADDR_W-1:0] REG_DONE_SUM   = 7'h5;  // rd: sum done flag
  localparam logic [PADDR_W-1:0] REG_ACCUM      = 7'hE;  // rd/wr: accumulator
  localparam logic [PADDR_W-1:0] REG_SW_EVENT   = 7'hF;  // rd/wr: sw events

  // request FSM shared by both masters
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID
  } tcdm_state_e;

endpackage

`default_nettype wire

//--- verilog/tcdm_fill_master.sv
/* write-burst engine on TCDM port 0, stores word k at base + 4*k
   started by a one-cycle pulse from the register file, reports done and a completion event */
`timescale 1ns/1ps
`default_nettype none

module tcdm_fill_master (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              start_i,
  input  logic [tcdm_probe_pkg::ADDR_W-1:0] base_i,
  input  logic                              gnt_i,
  input  logic                              rvalid_i,
  output logic                              req_o,
  output logic [tcdm_probe_pkg::ADDR_W-1:0] addr_o,
  output logic [tcdm_probe_pkg::DATA_W-1:0] wdata_o,
  output logic                              done_o,
  output logic                              event_o
);
  import tcdm_probe_pkg::*;

  tcdm_state_e      state_d, state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_inc;
  logic             cnt_en;
  logic             done_d, done_q;
  logic             last_beat;

  assign cnt_inc   = cnt_q + 1'b1;
  assign last_beat = cnt_q[CNT_W-1];  // set once all beats were granted

  assign addr_o  = base_i + ADDR_W'({cnt_q, 2'b00});
  assign wdata_o = DATA_W'(cnt_q);  // msb is clear while req is up
  assign done_o  = done_q;

  always_comb begin
    state_d = state_q;
    req_o   = 1'b0;
    cnt_en  = 1'b0;
    done_d  = 1'b0;
    event_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        done_d = 1'b1;
        if (start_i) begin
          done_d  = 1'b0;
          state_d = WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        req_o = 1'b1;
        if (gnt_i) begin
          cnt_en  = 1'b1;
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (rvalid_i) begin
          if (last_beat) begin
            done_d  = 1'b1;
            event_o = 1'b1;
            state_d = IDLE;
          end else begin
            req_o = 1'b1;  // next beat issued in the same cycle
            if (gnt_i) cnt_en = 1'b1;
            else state_d = WAIT_GNT;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
      if (cnt_en) cnt_q <= cnt_inc;
      else if (done_d) cnt_q[CNT_W-1] <= 1'b0;  // low bits already wrapped to zero
    end
  end

  // an ungranted request keeps its beat until the grant arrives
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o && !gnt_i |=> req_o && $stable(addr_o) && $stable(wdata_o));

endmodule

`default_nettype wire

//--- verilog/tcdm_sum_master.sv
/* read-burst engine on TCDM port 1, adds every returned word into a 32-bit accumulator
   the accumulator can be loaded from APB, which wins over a returning beat */
`timescale 1ns/1ps
`default_nettype none

module tcdm_sum_master (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              start_i,
  input  logic [tcdm_probe_pkg::ADDR_W-1:0] base_i,
  input  logic                              gnt_i,
  input  logic                              rvalid_i,
  input  logic [tcdm_probe_pkg::DATA_W-1:0] rdata_i,
  input  logic                              accum_load_i,
  input  logic [tcdm_probe_pkg::DATA_W-1:0] accum_wdata_i,
  output logic                              req_o,
  output logic [tcdm_probe_pkg::ADDR_W-1:0] addr_o,
  output logic                              done_o,
  output logic                              event_o,
  output logic [tcdm_probe_pkg::DATA_W-1:0] accum_o
);
  import tcdm_probe_pkg::*;

  tcdm_state_e       state_d, state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  cnt_inc;
  logic              cnt_en;
  logic              done_d, done_q;
  logic              last_beat;
  logic              acc_add;
  logic [DATA_W-1:0] accum_q;

  assign cnt_inc   = cnt_q + 1'b1;
  assign last_beat = cnt_q[CNT_W-1];

  assign addr_o  = base_i + ADDR_W'({cnt_q, 2'b00});
  assign done_o  = done_q;
  assign accum_o = accum_q;

  always_comb begin
    state_d = state_q;
    req_o   = 1'b0;
    cnt_en  = 1'b0;
    done_d  = 1'b0;
    event_o = 1'b0;
    acc_add = 1'b0;
    unique case (state_q)
      IDLE: begin
        done_d = 1'b1;
        if (start_i) begin
          done_d  = 1'b0;
          state_d = WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        req_o = 1'b1;
        if (gnt_i) begin
          cnt_en  = 1'b1;
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (rvalid_i) begin
          acc_add = 1'b1;  // every returned word counts
          if (last_beat) begin
            done_d  = 1'b1;
            event_o = 1'b1;
            state_d = IDLE;
          end else begin
            req_o = 1'b1;
            if (gnt_i) cnt_en = 1'b1;
            else state_d = WAIT_GNT;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b1;
      accum_q <= '0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
      if (cnt_en) cnt_q <= cnt_inc;
      else if (done_d) cnt_q[CNT_W-1] <= 1'b0;
      if (accum_load_i) accum_q <= accum_wdata_i;  // apb write takes priority
      else if (acc_add) accum_q <= accum_q + rdata_i;
    end
  end

  // completion fires on the final response, after exactly one burst of grants
  a_event_end : assert property (@(posedge clk_i) disable iff (!rst_ni)
    event_o |-> (state_q == WAIT_RVALID) && rvalid_i && (cnt_q == CNT_W'(BURST_LEN)));

endmodule

`default_nettype wire

//--- verilog/apb_ctrl_regs.sv
/* APB register file of the TCDM probe: start pulses, base and event registers, read-back
   writes land on the psel/penable/pwrite edge, reads are combinational with no wait state */
`timescale 1ns/1ps
`default_nettype none

module apb_ctrl_regs (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // apb slave
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [tcdm_probe_pkg::PADDR_W-1:0]  paddr_i,
  input  logic [tcdm_probe_pkg::DATA_W-1:0]   pwdata_i,
  output logic [tcdm_probe_pkg::DATA_W-1:0]   prdata_o,
  // fill master
  output logic                                fill_start_o,
  output logic [tcdm_probe_pkg::ADDR_W-1:0]   fill_base_o,
  input  logic                                fill_done_i,
  // sum master
  output logic                                sum_start_o,
  output logic [tcdm_probe_pkg::ADDR_W-1:0]   sum_base_o,
  input  logic                                sum_done_i,
  // accumulator of the sum master
  output logic                                accum_load_o,
  output logic [tcdm_probe_pkg::DATA_W-1:0]   accum_wdata_o,
  input  logic [tcdm_probe_pkg::DATA_W-1:0]   accum_i,
  output logic [tcdm_probe_pkg::SW_EVT_W-1:0] sw_event_o
);
  import tcdm_probe_pkg::*;

  logic                apb_wr, apb_rd;
  logic                is_start_fill, is_start_sum;
  logic                is_done_fill, is_done_sum;
  logic                is_accum, is_sw_event;
  logic [ADDR_W-1:0]   fill_base_q, sum_base_q;
  logic [SW_EVT_W-1:0] sw_event_q;

  assign apb_wr = psel_i & penable_i & pwrite_i;
  assign apb_rd = psel_i & penable_i & ~pwrite_i;

  // address decode
  assign is_start_fill = (paddr_i == REG_START_FILL);
  assign is_start_sum  = (paddr_i == REG_START_SUM);
  assign is_done_fill  = (paddr_i == REG_DONE_FILL);
  assign is_done_sum   = (paddr_i == REG_DONE_SUM);
  assign is_accum      = (paddr_i == REG_ACCUM);
  assign is_sw_event   = (paddr_i == REG_SW_EVENT);

  // a master only acts on the pulse when idle
  assign fill_start_o = apb_wr & is_start_fill;
  assign sum_start_o  = apb_wr & is_start_sum;

  assign accum_load_o  = apb_wr & is_accum;
  assign accum_wdata_o = pwdata_i;

  assign fill_base_o = fill_base_q;
  assign sum_base_o  = sum_base_q;
  assign sw_event_o  = sw_event_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_base_q <= '0;
      sum_base_q  <= '0;
      sw_event_q  <= '0;
    end else begin
      // bases follow every start write, even during a burst
      if (fill_start_o) fill_base_q <= pwdata_i[ADDR_W-1:0];
      if (sum_start_o) sum_base_q <= pwdata_i[ADDR_W-1:0];
      if (apb_wr && is_sw_event) sw_event_q <= pwdata_i[SW_EVT_W+1:2];
    end
  end

  // read-back mux, zero outside a read access and on unmapped indexes
  always_comb begin
    prdata_o = '0;
    if (apb_rd) begin
      if (is_done_fill) begin
        prdata_o = {{(DATA_W-1){1'b0}}, fill_done_i};
      end else if (is_done_sum) begin
        prdata_o = {{(DATA_W-1){1'b0}}, sum_done_i};
      end else if (is_accum) begin
        prdata_o = accum_i;
      end else if (is_sw_event) begin
        prdata_o = DATA_W'({sw_event_q, 2'b00});  // back in bits 15:2
      end
    end
  end

  // a write access has a single ACCESS cycle, so a start pulse lasts one cycle
  a_start_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fill_start_o || sum_start_o) |=> !(fill_start_o || sum_start_o));

endmodule

`default_nettype wire

//--- verilog/tcdm_probe_top.sv
/* top level of the TCDM probe, APB register port driving a fill and a sum master
   fill runs on TCDM port 0 (write only), sum on TCDM port 1 (read only) */
`timescale 1ns/1ps
`default_nettype none

module tcdm_probe_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // apb
  input  logic                               apb_psel_i,
  input  logic                               apb_penable_i,
  input  logic                               apb_pwrite_i,
  input  logic [tcdm_probe_pkg::PADDR_W-1:0] apb_paddr_i,
  input  logic [tcdm_probe_pkg::DATA_W-1:0]  apb_pwdata_i,
  output logic [tcdm_probe_pkg::DATA_W-1:0]  apb_prdata_o,
  // tcdm port 0, writes
  output logic                               tcdm0_req_o,
  output logic [tcdm_probe_pkg::ADDR_W-1:0]  tcdm0_addr_o,
  output logic [tcdm_probe_pkg::DATA_W-1:0]  tcdm0_wdata_o,
  input  logic                               tcdm0_gnt_i,
  input  logic                               tcdm0_rvalid_i,
  // tcdm port 1, reads
  output logic                               tcdm1_req_o,
  output logic [tcdm_probe_pkg::ADDR_W-1:0]  tcdm1_addr_o,
  input  logic                               tcdm1_gnt_i,
  input  logic                               tcdm1_rvalid_i,
  input  logic [tcdm_probe_pkg::DATA_W-1:0]  tcdm1_rdata_i,
  output logic [tcdm_probe_pkg::EVT_W-1:0]   events_o
);
  import tcdm_probe_pkg::*;

  logic                fill_start, sum_start;
  logic [ADDR_W-1:0]   fill_base, sum_base;
  logic                fill_done, sum_done;
  logic                fill_event, sum_event;
  logic                accum_load;
  logic [DATA_W-1:0]   accum_wdata, accum;
  logic [SW_EVT_W-1:0] sw_event;

  assign events_o = {sw_event, sum_event, fill_event};  // sw events sit in bits 15:2

  apb_ctrl_regs i_regs (
    .clk_i, .rst_ni,
    .psel_i        (apb_psel_i),
    .penable_i     (apb_penable_i),
    .pwrite_i      (apb_pwrite_i),
    .paddr_i       (apb_paddr_i),
    .pwdata_i      (apb_pwdata_i),
    .prdata_o      (apb_prdata_o),
    .fill_start_o  (fill_start),
    .fill_base_o   (fill_base),
    .fill_done_i   (fill_done),
    .sum_start_o   (sum_start),
    .sum_base_o    (sum_base),
    .sum_done_i    (sum_done),
    .accum_load_o  (accum_load),
    .accum_wdata_o (accum_wdata),
    .accum_i       (accum),
    .sw_event_o    (sw_event)
  );

  tcdm_fill_master i_fill (
    .clk_i, .rst_ni,
    .start_i  (fill_start),
    .base_i   (fill_base),
    .gnt_i    (tcdm0_gnt_i),
    .rvalid_i (tcdm0_rvalid_i),
    .req_o    (tcdm0_req_o),
    .addr_o   (tcdm0_addr_o),
    .wdata_o  (tcdm0_wdata_o),
    .done_o   (fill_done),
    .event_o  (fill_event)
  );

  tcdm_sum_master i_sum (
    .clk_i, .rst_ni,
    .start_i       (sum_start),
    .base_i        (sum_base),
    .gnt_i         (tcdm1_gnt_i),
    .rvalid_i      (tcdm1_rvalid_i),
    .rdata_i       (tcdm1_rdata_i),
    .accum_load_i  (accum_load),
    .accum_wdata_i (accum_wdata),
    .req_o         (tcdm1_req_o),
    .addr_o        (tcdm1_addr_o),
    .done_o        (sum_done),
    .event_o       (sum_event),
    .accum_o       (accum)
  );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
/* testbench clock and reset source, 100 ns clock period
   reset is held low for the first 4 cycles and released on a falling edge */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  localparam int HALF_PERIOD  = 50;  // ns
  localparam int RESET_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);  // release away from the active edge
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_tcdm_probe.sv
/* testbench of the TCDM probe: APB driver, TCDM memory model with random grants,
   directed tests for reset, fill, sum, concurrent bursts and software events */
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_probe;
  import tcdm_probe_pkg::*;

  localparam logic [31:0] SEED = 32'd62;
  localparam int MEM_AW = 10;  // word index bits of the model memory
  localparam int MEM_WORDS = 1 << MEM_AW;
  localparam int TIMEOUT_CYCLES = 4000;  // 5 tests x 64 beats x 8 cycles, plus margin

  logic clk, rst_n;
  logic apb_psel, apb_penable, apb_pwrite;
  logic [PADDR_W-1:0] apb_paddr;
  logic [DATA_W-1:0] apb_pwdata, apb_prdata;
  logic tcdm0_req, tcdm1_req;
  logic [ADDR_W-1:0] tcdm0_addr, tcdm1_addr;
  logic [DATA_W-1:0] tcdm0_wdata;
  logic tcdm0_gnt = 1'b0;
  logic tcdm0_rvalid = 1'b0;
  logic tcdm1_gnt = 1'b0;
  logic tcdm1_rvalid = 1'b0;
  logic [DATA_W-1:0] tcdm1_rdata = '0;
  logic [EVT_W-1:0] events;

  // memory model state
  logic [31:0] mem [0:MEM_WORDS-1];
  logic [31:0] gnt_rng = SEED;
  logic granted0 = 1'b0;
  logic granted1 = 1'b0;
  logic hold0 = 1'b0;
  logic hold1 = 1'b0;
  logic [ADDR_W-1:0] hold0_addr, hold1_addr;
  logic [DATA_W-1:0] hold0_wdata, rdata_next;
  logic [31:0] wr_addr_q[$], wr_data_q[$], rd_addr_q[$];
  int fill_events = 0;
  int sum_events = 0;
  int cycles = 0;
  string test_name = "startup";

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  tcdm_probe_top i_dut (
    .clk_i(clk), .rst_ni(rst_n),
    .apb_psel_i(apb_psel), .apb_penable_i(apb_penable), .apb_pwrite_i(apb_pwrite),
    .apb_paddr_i(apb_paddr), .apb_pwdata_i(apb_pwdata), .apb_prdata_o(apb_prdata),
    .tcdm0_req_o(tcdm0_req), .tcdm0_addr_o(tcdm0_addr), .tcdm0_wdata_o(tcdm0_wdata),
    .tcdm0_gnt_i(tcdm0_gnt), .tcdm0_rvalid_i(tcdm0_rvalid),
    .tcdm1_req_o(tcdm1_req), .tcdm1_addr_o(tcdm1_addr), .tcdm1_gnt_i(tcdm1_gnt),
    .tcdm1_rvalid_i(tcdm1_rvalid), .tcdm1_rdata_i(tcdm1_rdata),
    .events_o(events)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_stop();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: %s expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  // responses are sampled on the rising edge, where the DUT sees its inputs
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT never reported done", cycles);
      fail_stop();
    end else begin
      if (hold0) begin
        compare("port 0 req held", 32'd1, tcdm0_req);
        compare("port 0 addr held", hold0_addr, tcdm0_addr);
        compare("port 0 wdata held", hold0_wdata, tcdm0_wdata);
      end
      if (hold1) begin
        compare("port 1 req held", 32'd1, tcdm1_req);
        compare("port 1 addr held", hold1_addr, tcdm1_addr);
      end
      hold0 = tcdm0_req && !tcdm0_gnt;
      hold1 = tcdm1_req && !tcdm1_gnt;
      hold0_addr = tcdm0_addr;
      hold0_wdata = tcdm0_wdata;
      hold1_addr = tcdm1_addr;
      granted0 = tcdm0_req && tcdm0_gnt;
      granted1 = tcdm1_req && tcdm1_gnt;
      if (granted0) begin
        mem[tcdm0_addr[MEM_AW+1:2]] = tcdm0_wdata;
        wr_addr_q.push_back(tcdm0_addr);
        wr_data_q.push_back(tcdm0_wdata);
      end
      if (granted1) begin
        rd_addr_q.push_back(tcdm1_addr);
        rdata_next = mem[tcdm1_addr[MEM_AW+1:2]];
      end
      if (events[0]) fill_events = fill_events + 1;
      if (events[1]) sum_events = sum_events + 1;
    end
  end

  // random grants, one response cycle after each grant
  always @(negedge clk) begin
    gnt_rng = xorshift32(gnt_rng);
    tcdm0_gnt = gnt_rng[7];
    tcdm1_gnt = gnt_rng[19];
    tcdm0_rvalid = granted0;
    tcdm1_rvalid = granted1;
    tcdm1_rdata = granted1 ? rdata_next : gnt_rng;  // junk while no response
  end

  task automatic apb_write(input logic [PADDR_W-1:0] idx, input logic [31:0] data);
    apb_psel = 1'b1;
    apb_penable = 1'b0;
    apb_pwrite = 1'b1;
    apb_paddr = idx;
    apb_pwdata = data;
    @(negedge clk);
    apb_penable = 1'b1;
    @(negedge clk);
    apb_psel = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [PADDR_W-1:0] idx, output logic [31:0] data);
    apb_psel = 1'b1;
    apb_penable = 1'b0;
    apb_pwrite = 1'b0;
    apb_paddr = idx;
    @(negedge clk);
    apb_penable = 1'b1;
    @(posedge clk);
    data = apb_prdata;
    @(negedge clk);
    apb_psel = 1'b0;
    apb_penable = 1'b0;
  endtask

  task automatic wait_done(input logic [PADDR_W-1:0] idx);
    logic [31:0] rd;
    rd = '0;
    while (rd != 32'd1) apb_read(idx, rd);
  endtask

  task automatic clear_logs();
    wr_addr_q.delete();
    wr_data_q.delete();
    rd_addr_q.delete();
    fill_events = 0;
    sum_events = 0;
  endtask

  // expected sum of a 64 word window of the model memory plus a preset
  function automatic logic [31:0] window_sum(input logic [31:0] base, input logic [31:0] preset);
    logic [31:0] acc;
    acc = preset;
    for (int k = 0; k < BURST_LEN; k++) acc = acc + mem[(base >> 2) + k];
    return acc;
  endfunction

  task automatic verify_write_log(input logic [31:0] base);
    compare("write count", BURST_LEN, wr_addr_q.size());
    for (int k = 0; k < BURST_LEN; k++) begin
      compare("write address", base + 4 * k, wr_addr_q[k]);
      compare("write data", k, wr_data_q[k]);
      compare("stored word", k, mem[(base >> 2) + k]);
    end
  endtask

  task automatic verify_read_log(input logic [31:0] base);
    compare("read count", BURST_LEN, rd_addr_q.size());
    for (int k = 0; k < BURST_LEN; k++) compare("read address", base + 4 * k, rd_addr_q[k]);
  endtask

  task automatic check_reset_state();
    logic [31:0] rd;
    test_name = "reset state";
    apb_read(REG_DONE_FILL, rd);
    compare("fill done", 32'd1, rd);
    apb_read(REG_DONE_SUM, rd);
    compare("sum done", 32'd1, rd);
    apb_read(REG_ACCUM, rd);
    compare("accumulator", 32'd0, rd);
    @(posedge clk);
    compare("events", 32'd0, events);
    compare("port 0 req", 32'd0, tcdm0_req);
    compare("port 1 req", 32'd0, tcdm1_req);
    @(negedge clk);
  endtask

  task automatic run_fill_burst(input logic [31:0] base);
    logic [31:0] rd;
    test_name = "fill burst";
    clear_logs();
    apb_write(REG_START_FILL, base);
    apb_read(REG_DONE_FILL, rd);
    compare("fill done during burst", 32'd0, rd);
    wait_done(REG_DONE_FILL);
    compare("fill event count", 32'd1, fill_events);
    verify_write_log(base);
  endtask

  task automatic run_sum_burst(input logic [31:0] base, input logic [31:0] preset);
    logic [31:0] expected;
    logic [31:0] rd;
    test_name = "sum burst";
    clear_logs();
    expected = window_sum(base, preset);
    apb_write(REG_ACCUM, preset);
    apb_read(REG_ACCUM, rd);
    compare("accumulator preset", preset, rd);
    apb_write(REG_START_SUM, base);
    wait_done(REG_DONE_SUM);
    compare("sum event count", 32'd1, sum_events);
    verify_read_log(base);
    apb_read(REG_ACCUM, rd);
    compare("accumulator", expected, rd);
  endtask

  // fill and sum windows are disjoint, so the expected sum is known up front
  task automatic run_concurrent_bursts(input logic [31:0] fill_base, input logic [31:0] sum_base,
                                       input logic [31:0] preset);
    logic [31:0] expected;
    logic [31:0] rd;
    test_name = "concurrent bursts";
    clear_logs();
    expected = window_sum(sum_base, preset);
    apb_write(REG_ACCUM, preset);
    apb_write(REG_START_FILL, fill_base);
    apb_write(REG_START_SUM, sum_base);
    wait_done(REG_DONE_FILL);
    wait_done(REG_DONE_SUM);
    compare("fill event count", 32'd1, fill_events);
    compare("sum event count", 32'd1, sum_events);
    verify_write_log(fill_base);
    verify_read_log(sum_base);
    apb_read(REG_ACCUM, rd);
    compare("accumulator", expected, rd);
  endtask

  task automatic check_sw_events();
    logic [31:0] value;
    logic [31:0] rd;
    test_name = "software events";
    value = 32'hA5A5_5A5B;
    repeat (2) begin
      apb_write(REG_SW_EVENT, value);
      @(posedge clk);
      compare("events", {16'h0, value[15:2], 2'b00}, events);  // completion bits stay low
      @(negedge clk);
      apb_read(REG_SW_EVENT, rd);
      compare("sw event read-back", value & 32'h0000_FFFC, rd);
      value = ~value;
    end
  endtask

  initial begin
    apb_psel = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite = 1'b0;
    apb_paddr = '0;
    apb_pwdata = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = xorshift32(xorshift32(SEED + i));
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_reset_state();
    run_fill_burst(32'h0000_0100);
    run_sum_burst(32'h0000_0400, 32'h1234_5678);
    run_concurrent_bursts(32'h0000_0800, 32'h0000_0C00, 32'hFFFF_FF00);
    check_sw_events();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/tcdm_probe_pkg.sv
verilog/tcdm_fill_master.sv
verilog/tcdm_sum_master.sv
verilog/apb_ctrl_regs.sv
verilog/tcdm_probe_top.sv
verif/tb_clk_gen.sv
verif/tb_tcdm_probe.sv
